// File: all.f
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_mul.sv
verilog/ex_div.sv
verilog/hilo_reg.sv
verilog/ex_ctrl.sv
verilog/ex_top.sv
dv/ex_tb.sv

// File: Makefile
# Verilator build and run for the execute unit testbench

SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

obj_dir/Vex_tb: all.f $(SRCS)
	verilator --binary --timing --assert --top-module ex_tb -f all.f -o Vex_tb

# pass only if the pass line shows up in the simulator output
run: obj_dir/Vex_tb
	@out="$$(obj_dir/Vex_tb)"; echo "$$out"; echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir

// File: dv/ex_tb.sv
// testbench for ex_top with LCG stimulus, reference model, output checks and watchdog
`timescale 1ns/1ps

module ex_tb;
    import ex_pkg::*;

    localparam int N_RAND = 8;
    localparam int N_RAND_OPS = 13;
    // reset reads, random ops, count corners, add/sub, mul, div, HI/LO moves and hold
    localparam int N_TXN = 2 + N_RAND_OPS * N_RAND + 4 + 6 + 2 * N_RAND + 7 * N_RAND
                           + 6 * N_RAND + 7;
    localparam int ACK_LIMIT = DIV_STEPS + 10;
    localparam int CYCLE_LIMIT = N_TXN * ACK_LIMIT + 40;
    localparam aluop_e RAND_OPS [N_RAND_OPS] = '{OP_OR, OP_AND, OP_NOR, OP_XOR, OP_SLL,
        OP_SRL, OP_SRA, OP_ADDU, OP_SUBU, OP_SLT, OP_SLTU, OP_CLZ, OP_CLO};

    logic               clk;
    logic               rst_n_i;
    logic               req_i;
    aluop_e             aluop_i;
    logic [REG_W-1:0]   reg1_i;
    logic [REG_W-1:0]   reg2_i;
    logic [RADDR_W-1:0] wd_i;
    logic               wreg_i;
    logic               ack_o;
    logic [REG_W-1:0]   wdata_o;
    logic [RADDR_W-1:0] wd_o;
    logic               wreg_o;
    logic               ovf_o;

    logic [31:0]        lcg_state;
    logic [31:0]        op_a;
    logic [31:0]        op_b;
    logic [REG_W-1:0]   exp_wdata;
    logic [RADDR_W-1:0] exp_wd;
    logic               exp_wreg;
    logic               exp_ovf;
    logic [REG_W-1:0]   model_hi;
    logic [REG_W-1:0]   model_lo;
    string              test_name;
    int                 errors = 0;
    int                 checks = 0;
    int                 txn_count = 0;
    int                 ack_count = 0;
    int                 cycles;

    ex_top UUT (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (req_i),
        .aluop_i (aluop_i),
        .reg1_i  (reg1_i),
        .reg2_i  (reg2_i),
        .wd_i    (wd_i),
        .wreg_i  (wreg_i),
        .ack_o   (ack_o),
        .wdata_o (wdata_o),
        .wd_o    (wd_o),
        .wreg_o  (wreg_o),
        .ovf_o   (ovf_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // run of bits equal to bit_val counted from bit 31 down
    function automatic logic [31:0] lead_count(logic [31:0] w, logic bit_val);
        logic [31:0] n;
        logic        stop;
        n = '0;
        stop = 1'b0;
        for (int i = 31; i >= 0; i--)
        begin
            if (!stop && (w[i] == bit_val))
                n = n + 32'd1;
            else
                stop = 1'b1;
        end
        return n;
    endfunction

    // expected {wdata, wreg, ovf, hi, lo}
    function automatic logic [97:0] model_result(aluop_e op, logic [31:0] a, logic [31:0] b,
                                                 logic wreg_in, logic [31:0] hi_in,
                                                 logic [31:0] lo_in);
        logic [31:0] wdata;
        logic        ovf;
        logic [32:0] wide;
        logic [63:0] prod;
        logic [31:0] hi_out;
        logic [31:0] lo_out;
        wdata = '0;
        ovf = 1'b0;
        hi_out = hi_in;
        lo_out = lo_in;
        case (op)
            OP_OR:   wdata = a | b;
            OP_AND:  wdata = a & b;
            OP_NOR:  wdata = ~(a | b);
            OP_XOR:  wdata = a ^ b;
            OP_SLL:  wdata = b << a[4:0];
            OP_SRL:  wdata = b >> a[4:0];
            OP_SRA:  wdata = $signed(b) >>> a[4:0];
            OP_ADD, OP_ADDU:
            begin
                wdata = a + b;
                // sign-extended sum, overflow when the two top bits disagree
                wide = {a[31], a} + {b[31], b};
                ovf = (op == OP_ADD) && (wide[32] != wide[31]);
            end
            OP_SUB, OP_SUBU:
            begin
                wdata = a - b;
                wide = {a[31], a} - {b[31], b};
                ovf = (op == OP_SUB) && (wide[32] != wide[31]);
            end
            OP_SLT:  wdata = {31'd0, $signed(a) < $signed(b)};
            OP_SLTU: wdata = {31'd0, a < b};
            OP_CLZ:  wdata = lead_count(a, 1'b0);
            OP_CLO:  wdata = lead_count(a, 1'b1);
            OP_MUL:
            begin
                prod = longint'($signed(a)) * longint'($signed(b));
                wdata = prod[31:0];
            end
            OP_MULT:
            begin
                prod = longint'($signed(a)) * longint'($signed(b));
                {hi_out, lo_out} = prod;
            end
            OP_MULTU:
            begin
                prod = {32'd0, a} * {32'd0, b};
                {hi_out, lo_out} = prod;
            end
            OP_DIV:
            begin
                hi_out = $signed(a) % $signed(b);
                lo_out = $signed(a) / $signed(b);
            end
            OP_DIVU:
            begin
                hi_out = a % b;
                lo_out = a / b;
            end
            OP_MFHI: wdata = hi_in;
            OP_MFLO: wdata = lo_in;
            OP_MTHI: hi_out = a;
            OP_MTLO: lo_out = a;
            default: wdata = '0;
        endcase
        return {wdata, wreg_in && !ovf, ovf, hi_out, lo_out};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual)
        begin
            errors++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one full four-phase transaction, entered and left on a falling edge
    task automatic run_op(input aluop_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic wr, input int hold);
        logic [31:0] rnd;
        int          waited;
        rnd = next_rand();
        {exp_wdata, exp_wreg, exp_ovf, model_hi, model_lo} =
            model_result(op, a, b, wr, model_hi, model_lo);
        exp_wd = rnd[4:0];
        test_name = $sformatf("%s #%0d", op.name(), txn_count);
        txn_count++;
        aluop_i = op;
        reg1_i = a;
        reg2_i = b;
        wd_i = rnd[4:0];
        wreg_i = wr;
        req_i = 1'b1;
        waited = 0;
        while (!ack_o && (waited < ACK_LIMIT))
        begin
            @(negedge clk);
            waited++;
        end
        if (!ack_o)
        begin
            errors++;
            $display("ack_o never rose for %s", test_name);
        end
        else if ((op == OP_DIV) || (op == OP_DIVU))
        begin
            if (waited < DIV_STEPS + 2)
            begin
                errors++;
                $display("%s acknowledged after only %0d cycles", test_name, waited);
            end
        end
        else
            check_value({test_name, " ack latency"}, 64'(2), 64'(waited));
        // requester keeps req high, outputs must hold
        for (int k = 0; k < hold; k++)
        begin
            @(negedge clk);
            check_value({test_name, " held ack_o"}, 64'(1), 64'(ack_o));
            check_value({test_name, " held wdata_o"}, 64'(exp_wdata), 64'(wdata_o));
        end
        req_i = 1'b0;
        waited = 0;
        while (ack_o && (waited < ACK_LIMIT))
        begin
            @(negedge clk);
            waited++;
        end
        if (ack_o)
        begin
            errors++;
            $display("ack_o stayed high after req_i dropped for %s", test_name);
        end
    endtask

    // outputs are registered with the ack edge, sampled half a cycle later
    always @(posedge ack_o)
    begin
        if (rst_n_i)
        begin
            @(negedge clk);
            ack_count++;
            check_value({test_name, " wdata_o"}, 64'(exp_wdata), 64'(wdata_o));
            check_value({test_name, " wd_o"}, 64'(exp_wd), 64'(wd_o));
            check_value({test_name, " wreg_o"}, 64'(exp_wreg), 64'(wreg_o));
            check_value({test_name, " ovf_o"}, 64'(exp_ovf), 64'(ovf_o));
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        req_i = 1'b0;
        aluop_i = OP_NOP;
        reg1_i = '0;
        reg2_i = '0;
        wd_i = '0;
        wreg_i = 1'b0;
        rst_n_i = 1'b0;
        lcg_state = 32'h7deee017;
        model_hi = '0;
        model_lo = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        @(negedge clk);

        check_value("reset ack_o", 64'(0), 64'(ack_o));
        check_value("reset wreg_o", 64'(0), 64'(wreg_o));
        check_value("reset ovf_o", 64'(0), 64'(ovf_o));
        check_value("reset wdata_o", 64'(0), 64'(wdata_o));
        run_op(OP_MFHI, '0, '0, 1'b1, 0);
        run_op(OP_MFLO, '0, '0, 1'b1, 0);

        for (int i = 0; i < N_RAND_OPS; i++)
        begin
            for (int j = 0; j < N_RAND; j++)
            begin
                op_a = next_rand();
                op_b = next_rand();
                // spread leading counts over the whole range
                if (RAND_OPS[i] == OP_CLZ)
                    op_a = op_a >> op_b[4:0];
                if (RAND_OPS[i] == OP_CLO)
                    op_a = ~(op_a >> op_b[4:0]);
                run_op(RAND_OPS[i], op_a, op_b, op_b[8] | op_b[9], 0);
            end
        end
        run_op(OP_CLZ, 32'h0000_0000, '0, 1'b1, 0);
        run_op(OP_CLZ, 32'hffff_ffff, '0, 1'b1, 0);
        run_op(OP_CLO, 32'h0000_0000, '0, 1'b1, 0);
        run_op(OP_CLO, 32'hffff_ffff, '0, 1'b1, 0);

        // signed boundaries, the last two stay in range
        run_op(OP_ADD, 32'h7fff_ffff, 32'h0000_0001, 1'b1, 0);
        run_op(OP_ADD, 32'h8000_0000, 32'hffff_ffff, 1'b1, 0);
        run_op(OP_SUB, 32'h8000_0000, 32'h0000_0001, 1'b1, 0);
        run_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff, 1'b1, 0);
        run_op(OP_ADD, 32'h7fff_fffe, 32'h0000_0001, 1'b1, 0);
        run_op(OP_SUB, 32'h8000_0001, 32'h0000_0001, 1'b1, 0);
        for (int j = 0; j < N_RAND; j++)
        begin
            op_a = next_rand();
            op_b = next_rand();
            run_op(OP_ADD, op_a, op_b, 1'b1, 0);
            run_op(OP_SUB, op_b, op_a, 1'b1, 0);
        end

        for (int j = 0; j < N_RAND; j++)
        begin
            op_a = next_rand();
            op_b = next_rand();
            if (j % 2 == 1)
                op_a[31] = 1'b1;
            if (j % 4 >= 2)
                op_b[31] = 1'b1;
            run_op(OP_MUL, op_a, op_b, 1'b1, 0);
            run_op(OP_MULT, op_a, op_b, 1'b0, 0);
            run_op(OP_MFHI, '0, '0, 1'b1, 0);
            run_op(OP_MFLO, '0, '0, 1'b1, 0);
            run_op(OP_MULTU, op_a, op_b, 1'b0, 0);
            run_op(OP_MFHI, '0, '0, 1'b1, 0);
            run_op(OP_MFLO, '0, '0, 1'b1, 0);
        end

        for (int j = 0; j < N_RAND; j++)
        begin
            op_a = next_rand();
            op_b = next_rand() >> op_a[4:0];
            if (op_b == '0)
                op_b = 32'd1;
            if ((op_a == 32'h8000_0000) && (op_b == 32'hffff_ffff))
                op_b = 32'd1;
            run_op(OP_DIV, op_a, op_b, 1'b0, 0);
            run_op(OP_MFHI, '0, '0, 1'b1, 0);
            run_op(OP_MFLO, '0, '0, 1'b1, 0);
            run_op(OP_DIVU, op_a, op_b, 1'b0, 0);
            run_op(OP_MFHI, '0, '0, 1'b1, 0);
            run_op(OP_MFLO, '0, '0, 1'b1, 0);
        end

        op_a = next_rand();
        op_b = next_rand();
        // LO read right after mthi, before mtlo overwrites it
        run_op(OP_MTHI, op_a, '0, 1'b0, 0);
        run_op(OP_MFLO, '0, '0, 1'b1, 0);
        run_op(OP_MTLO, op_b, '0, 1'b0, 0);
        run_op(OP_MFHI, '0, '0, 1'b1, 0);
        run_op(OP_MFLO, '0, '0, 1'b1, 0);
        // back-pressure, then a fresh request once ack has dropped
        run_op(OP_XOR, op_a, op_b, 1'b1, 5);
        run_op(OP_MFHI, '0, '0, 1'b1, 0);

        if (ack_count != txn_count)
        begin
            errors++;
            $display("saw %0d acknowledges for %0d requests", ack_count, txn_count);
        end
        $display("transactions: %0d, checks: %0d, errors: %0d", txn_count, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: verilog/ex_top.sv
// execute unit top level joining controller, ALU, multiplier, divider and HI/LO
`timescale 1ns/1ps

module ex_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  ex_pkg::aluop_e             aluop_i,
    input  logic [ex_pkg::REG_W-1:0]   reg1_i,
    input  logic [ex_pkg::REG_W-1:0]   reg2_i,
    input  logic [ex_pkg::RADDR_W-1:0] wd_i,
    input  logic                       wreg_i,
    output logic                       ack_o,
    output logic [ex_pkg::REG_W-1:0]   wdata_o,
    output logic [ex_pkg::RADDR_W-1:0] wd_o,
    output logic                       wreg_o,
    output logic                       ovf_o
);
    import ex_pkg::*;

    logic [REG_W-1:0]  alu_result;
    logic              alu_ovf;
    logic [DREG_W-1:0] mul_product;
    logic [REG_W-1:0]  hi;
    logic [REG_W-1:0]  lo;
    logic              div_start;
    logic              div_signed;
    logic [REG_W-1:0]  div_dividend;
    logic [REG_W-1:0]  div_divisor;
    logic              div_ready;
    logic [DREG_W-1:0] div_result;
    logic              hilo_we;
    logic [REG_W-1:0]  hi_wdata;
    logic [REG_W-1:0]  lo_wdata;

    ex_ctrl u_ctrl (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .req_i          (req_i),
        .aluop_i        (aluop_i),
        .reg1_i         (reg1_i),
        .reg2_i         (reg2_i),
        .wd_i           (wd_i),
        .wreg_i         (wreg_i),
        .alu_result_i   (alu_result),
        .alu_ovf_i      (alu_ovf),
        .mul_product_i  (mul_product),
        .hi_i           (hi),
        .lo_i           (lo),
        .div_ready_i    (div_ready),
        .div_result_i   (div_result),
        .div_start_o    (div_start),
        .div_signed_o   (div_signed),
        .div_dividend_o (div_dividend),
        .div_divisor_o  (div_divisor),
        .hilo_we_o      (hilo_we),
        .hi_wdata_o     (hi_wdata),
        .lo_wdata_o     (lo_wdata),
        .ack_o          (ack_o),
        .wdata_o        (wdata_o),
        .wd_o           (wd_o),
        .wreg_o         (wreg_o),
        .ovf_o          (ovf_o)
    );

    ex_alu u_alu (
        .aluop_i      (aluop_i),
        .reg1_i       (reg1_i),
        .reg2_i       (reg2_i),
        .alu_result_o (alu_result),
        .alu_ovf_o    (alu_ovf)
    );

    ex_mul u_mul (
        .aluop_i       (aluop_i),
        .reg1_i        (reg1_i),
        .reg2_i        (reg2_i),
        .mul_product_o (mul_product)
    );

    ex_div u_div (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .div_start_i    (div_start),
        .div_signed_i   (div_signed),
        .div_dividend_i (div_dividend),
        .div_divisor_i  (div_divisor),
        .div_ready_o    (div_ready),
        .div_result_o   (div_result)
    );

    hilo_reg u_hilo (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .hilo_we_i  (hilo_we),
        .hi_wdata_i (hi_wdata),
        .lo_wdata_i (lo_wdata),
        .hi_o       (hi),
        .lo_o       (lo)
    );

endmodule

// File: verilog/ex_ctrl.sv
// req/ack sequencer with divider launch, result selection and HI/LO write control
`timescale 1ns/1ps

module ex_ctrl (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  ex_pkg::aluop_e             aluop_i,
    input  logic [ex_pkg::REG_W-1:0]   reg1_i,
    input  logic [ex_pkg::REG_W-1:0]   reg2_i,
    input  logic [ex_pkg::RADDR_W-1:0] wd_i,
    input  logic                       wreg_i,
    input  logic [ex_pkg::REG_W-1:0]   alu_result_i,
    input  logic                       alu_ovf_i,
    input  logic [ex_pkg::DREG_W-1:0]  mul_product_i,
    input  logic [ex_pkg::REG_W-1:0]   hi_i,
    input  logic [ex_pkg::REG_W-1:0]   lo_i,
    input  logic                       div_ready_i,
    input  logic [ex_pkg::DREG_W-1:0]  div_result_i,
    output logic                       div_start_o,
    output logic                       div_signed_o,
    output logic [ex_pkg::REG_W-1:0]   div_dividend_o,
    output logic [ex_pkg::REG_W-1:0]   div_divisor_o,
    output logic                       hilo_we_o,
    output logic [ex_pkg::REG_W-1:0]   hi_wdata_o,
    output logic [ex_pkg::REG_W-1:0]   lo_wdata_o,
    output logic                       ack_o,
    output logic [ex_pkg::REG_W-1:0]   wdata_o,
    output logic [ex_pkg::RADDR_W-1:0] wd_o,
    output logic                       wreg_o,
    output logic                       ovf_o
);
    import ex_pkg::*;

    ctrl_state_e      state;
    ctrl_state_e      state_next;
    logic             req_q;
    logic             is_div;
    logic             commit;
    logic             hilo_op;
    logic [REG_W-1:0] result;

    assign is_div = (aluop_i == OP_DIV) || (aluop_i == OP_DIVU);

    // results and HI/LO land on the edge that enters ST_DONE
    assign commit = ((state == ST_IDLE) && req_q && !is_div) ||
                    ((state == ST_DIV) && div_ready_i);

    always_comb
    begin
        state_next = state;
        case (state)
            ST_IDLE: if (req_q) state_next = is_div ? ST_DIV : ST_DONE;
            ST_DIV:  if (div_ready_i) state_next = ST_DONE;
            ST_DONE: if (!req_q) state_next = ST_IDLE;
            default: state_next = ST_IDLE;
        endcase
    end

    // req is registered once, which sets both the ack and the release latency
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            req_q <= 1'b0;
            state <= ST_IDLE;
        end
        else
        begin
            req_q <= req_i;
            state <= state_next;
        end
    end

    assign ack_o = (state == ST_DONE);

    // divider operands come straight from the held request
    assign div_start_o    = (state == ST_DIV);
    assign div_signed_o   = (aluop_i == OP_DIV);
    assign div_dividend_o = reg1_i;
    assign div_divisor_o  = reg2_i;

    always_comb
    begin
        case (aluop_i)
            OP_MUL:  result = mul_product_i[REG_W-1:0];
            OP_MFHI: result = hi_i;
            OP_MFLO: result = lo_i;
            OP_NOP, OP_MULT, OP_MULTU, OP_DIV, OP_DIVU, OP_MTHI, OP_MTLO:
            begin
                result = '0;
            end
            default: result = alu_result_i;
        endcase
    end

    always_comb
    begin
        hilo_op    = 1'b1;
        hi_wdata_o = hi_i;
        lo_wdata_o = lo_i;
        case (aluop_i)
            OP_MULT, OP_MULTU: {hi_wdata_o, lo_wdata_o} = mul_product_i;
            OP_DIV, OP_DIVU:   {hi_wdata_o, lo_wdata_o} = div_result_i;
            // mthi keeps LO, mtlo keeps HI
            OP_MTHI:           hi_wdata_o = reg1_i;
            OP_MTLO:           lo_wdata_o = reg1_i;
            default:           hilo_op = 1'b0;
        endcase
    end

    assign hilo_we_o = commit && hilo_op;

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wdata_o <= '0;
            wd_o    <= '0;
            wreg_o  <= 1'b0;
            ovf_o   <= 1'b0;
        end
        else if (commit)
        begin
            wdata_o <= result;
            wd_o    <= wd_i;
            // an overflowing add or sub must not write back
            wreg_o  <= wreg_i && !alu_ovf_i;
            ovf_o   <= alu_ovf_i;
        end
    end

    // the request must still be up on the edge that raises ack
    assert property (@(posedge clk) disable iff (!rst_n_i) $rose(ack_o) |-> $past(req_i))
        else $error("ack raised without a pending request");

    // HI/LO only move on the edge that raises ack
    assert property (@(posedge clk) disable iff (!rst_n_i)
        !$stable({hi_i, lo_i}) |-> $rose(ack_o))
        else $error("HI/LO written away from the ack edge");

endmodule

// File: verilog/hilo_reg.sv
// architectural HI and LO registers with a shared write enable
`timescale 1ns/1ps

module hilo_reg (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     hilo_we_i,
    input  logic [ex_pkg::REG_W-1:0] hi_wdata_i,
    input  logic [ex_pkg::REG_W-1:0] lo_wdata_i,
    output logic [ex_pkg::REG_W-1:0] hi_o,
    output logic [ex_pkg::REG_W-1:0] lo_o
);

    // both halves always written together
    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            hi_o <= '0;
            lo_o <= '0;
        end
        else if (hilo_we_i)
        begin
            hi_o <= hi_wdata_i;
            lo_o <= lo_wdata_i;
        end
    end

    // unknown data here would corrupt architectural state
    assert property (@(posedge clk) disable iff (!rst_n_i)
        hilo_we_i |-> !$isunknown({hi_wdata_i, lo_wdata_i}))
        else $error("HI/LO write with unknown data");

endmodule

// File: verilog/ex_div.sv
// iterative restoring divider, one quotient bit per clock, with start/ready handshake
`timescale 1ns/1ps

module ex_div (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      div_start_i,
    input  logic                      div_signed_i,
    input  logic [ex_pkg::REG_W-1:0]  div_dividend_i,
    input  logic [ex_pkg::REG_W-1:0]  div_divisor_i,
    output logic                      div_ready_o,
    output logic [ex_pkg::DREG_W-1:0] div_result_o
);
    import ex_pkg::*;

    typedef logic [$clog2(DIV_STEPS):0] cnt_t;

    logic             running;
    cnt_t             step_cnt;
    logic             load;
    logic             last_step;
    logic [REG_W-1:0] quot;
    logic [REG_W-1:0] rem;
    logic [REG_W-1:0] divisor_mag;
    logic             neg_quot;
    logic             neg_rem;
    logic [REG_W:0]   trial;
    logic [REG_W:0]   diff;

    // accept a new start only once the previous result is released
    assign load      = div_start_i && !running && !div_ready_o;
    assign last_step = (step_cnt == cnt_t'(DIV_STEPS));

    // shift the next dividend bit into the partial remainder
    assign trial = {rem, quot[REG_W-1]};
    assign diff  = trial - {1'b0, divisor_mag};

    always_ff @(posedge clk or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            running     <= 1'b0;
            step_cnt    <= '0;
            div_ready_o <= 1'b0;
        end
        else if (load)
        begin
            running  <= 1'b1;
            step_cnt <= '0;
        end
        else if (running)
        begin
            if (last_step)
            begin
                running     <= 1'b0;
                div_ready_o <= 1'b1;
            end
            else
            begin
                step_cnt <= step_cnt + cnt_t'(1);
            end
        end
        else if (div_ready_o && !div_start_i)
        begin
            div_ready_o <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            quot        <= (div_signed_i && div_dividend_i[REG_W-1]) ? -div_dividend_i
                                                                     : div_dividend_i;
            divisor_mag <= (div_signed_i && div_divisor_i[REG_W-1]) ? -div_divisor_i
                                                                    : div_divisor_i;
            rem         <= '0;
            neg_quot    <= div_signed_i && (div_dividend_i[REG_W-1] ^ div_divisor_i[REG_W-1]);
            neg_rem     <= div_signed_i && div_dividend_i[REG_W-1];
        end
        else if (running && !last_step)
        begin
            // restore when the trial subtraction goes negative
            if (!diff[REG_W])
            begin
                rem  <= diff[REG_W-1:0];
                quot <= {quot[REG_W-2:0], 1'b1};
            end
            else
            begin
                rem  <= trial[REG_W-1:0];
                quot <= {quot[REG_W-2:0], 1'b0};
            end
        end
        else if (running && last_step)
        begin
            // remainder in the upper word, quotient in the lower
            div_result_o <= {neg_rem ? -rem : rem, neg_quot ? -quot : quot};
        end
    end

    // requester must hold start until the result is ready
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (div_start_i && !div_ready_o) |=> div_start_i)
        else $error("divider start dropped before ready");

endmodule

// File: verilog/ex_mul.sv
// signed and unsigned 32x32 multiplier with a 64-bit product
`timescale 1ns/1ps

module ex_mul (
    input  ex_pkg::aluop_e            aluop_i,
    input  logic [ex_pkg::REG_W-1:0]  reg1_i,
    input  logic [ex_pkg::REG_W-1:0]  reg2_i,
    output logic [ex_pkg::DREG_W-1:0] mul_product_o
);
    import ex_pkg::*;

    logic              signed_op;
    logic [REG_W-1:0]  opa;
    logic [REG_W-1:0]  opb;
    logic [DREG_W-1:0] mag_product;

    assign signed_op = (aluop_i == OP_MUL) || (aluop_i == OP_MULT);

    // magnitudes of negative operands for the signed forms
    assign opa = (signed_op && reg1_i[REG_W-1]) ? -reg1_i : reg1_i;
    assign opb = (signed_op && reg2_i[REG_W-1]) ? -reg2_i : reg2_i;

    assign mag_product = DREG_W'(opa) * DREG_W'(opb);

    // product is negative when exactly one operand was
    assign mul_product_o = (signed_op && (reg1_i[REG_W-1] ^ reg2_i[REG_W-1])) ?
                           -mag_product : mag_product;

endmodule

// File: verilog/ex_alu.sv
// single-cycle ALU with logic, shift, add/sub, set-less-than, leading counts and overflow
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::aluop_e            aluop_i,
    input  logic [ex_pkg::REG_W-1:0]  reg1_i,
    input  logic [ex_pkg::REG_W-1:0]  reg2_i,
    output logic [ex_pkg::REG_W-1:0]  alu_result_o,
    output logic                      alu_ovf_o
);
    import ex_pkg::*;

    typedef logic [SHAMT_W:0] lead_t;

    logic               negate_b;
    logic [REG_W-1:0]   reg2_mux;
    logic [REG_W-1:0]   sum;
    logic               sum_ovf;
    logic               reg1_lt_reg2;
    logic [SHAMT_W-1:0] shamt;
    logic [REG_W-1:0]   lead_src;
    lead_t              lead_cnt;

    // sub, subu and slt add the two's complement of operand 2
    assign negate_b = (aluop_i == OP_SUB) || (aluop_i == OP_SUBU) || (aluop_i == OP_SLT);
    assign reg2_mux = negate_b ? -reg2_i : reg2_i;
    assign sum      = reg1_i + reg2_mux;

    // add overflows on equal signs, sub on differing signs, when the sum sign flips
    assign sum_ovf = (reg1_i[REG_W-1] ^ sum[REG_W-1]) &
                     (reg1_i[REG_W-1] ^ reg2_i[REG_W-1] ^ ~negate_b);

    // signed compare from the sign bits, with the difference sign when they agree
    assign reg1_lt_reg2 = (aluop_i == OP_SLT) ?
        ((reg1_i[REG_W-1] && !reg2_i[REG_W-1]) ||
         (!reg1_i[REG_W-1] && !reg2_i[REG_W-1] && sum[REG_W-1]) ||
         (reg1_i[REG_W-1] && reg2_i[REG_W-1] && sum[REG_W-1])) :
        (reg1_i < reg2_i);

    assign shamt = reg1_i[SHAMT_W-1:0];

    // clo counts the leading zeros of the inverted word
    assign lead_src = (aluop_i == OP_CLO) ? ~reg1_i : reg1_i;

    always_comb
    begin
        lead_cnt = lead_t'(REG_W);
        // the highest set bit wins since it is visited last
        for (int i = 0; i < REG_W; i++)
        begin
            if (lead_src[i])
            begin
                lead_cnt = lead_t'(REG_W - 1 - i);
            end
        end
    end

    always_comb
    begin
        case (aluop_i)
            OP_OR:   alu_result_o = reg1_i | reg2_i;
            OP_AND:  alu_result_o = reg1_i & reg2_i;
            OP_NOR:  alu_result_o = ~(reg1_i | reg2_i);
            OP_XOR:  alu_result_o = reg1_i ^ reg2_i;
            OP_SLL:  alu_result_o = reg2_i << shamt;
            OP_SRL:  alu_result_o = reg2_i >> shamt;
            OP_SRA:  alu_result_o = $signed(reg2_i) >>> shamt;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU:
            begin
                alu_result_o = sum;
            end
            OP_SLT, OP_SLTU:
            begin
                alu_result_o = REG_W'(reg1_lt_reg2);
            end
            OP_CLZ, OP_CLO:
            begin
                alu_result_o = REG_W'(lead_cnt);
            end
            default: alu_result_o = '0;
        endcase
    end

    // only the trapping forms report overflow
    assign alu_ovf_o = ((aluop_i == OP_ADD) || (aluop_i == OP_SUB)) && sum_ovf;

endmodule

// File: verilog/ex_pkg.sv
// shared widths, operation codes and controller states for the execute unit
package ex_pkg;

    // general register and HI/LO half width
    localparam int REG_W = 32;
    // full product, or the HI/LO pair
    localparam int DREG_W = 64;
    // destination register number
    localparam int RADDR_W = 5;
    // operand bits that carry a shift amount
    localparam int SHAMT_W = 5;
    // divider iterations, one per quotient bit
    localparam int DIV_STEPS = 32;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_DIV,
        OP_DIVU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } aluop_e;

    // idle, waiting on the divider, result held until req drops
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIV,
        ST_DONE
    } ctrl_state_e;

endpackage
